//--- hw/buf_if.sv
`timescale 1ns/1ps

// ============================================================
// Write side of the packet buffer
// ============================================================
interface buf_wr_if;
  import mpd_pkg::*;

  // Receiver to buffer
  logic       alloc;
  logic       wr_en;
  buf_addr_t  addr;
  byte_t      data;
  logic       commit;
  logic       abort;
  frame_len_t len;

  // Buffer to receiver, lowest free slot and whether any is free
  slot_id_t   free_slot;
  logic       slot_avail;

  modport wr  (output alloc, wr_en, addr, data, commit, abort, len,
               input  free_slot, slot_avail);
  modport mem (input  alloc, wr_en, addr, data, commit, abort, len,
               output free_slot, slot_avail);
endinterface

// ============================================================
// Read side of the packet buffer
// ============================================================
interface buf_rd_if;
  import mpd_pkg::*;

  // Transmitter to buffer
  slot_id_t   slot;
  buf_addr_t  addr;
  logic       release_stb;

  // Combinational read back
  byte_t      data;
  frame_len_t len;

  modport rd  (output slot, addr, release_stb, input  data, len);
  modport mem (input  slot, addr, release_stb, output data, len);
endinterface

//--- hw/frame_receiver.sv
`timescale 1ns/1ps

module frame_receiver (
  input  logic                CLK,
  input  logic                RST_N,
  input  mpd_pkg::byte_t      rx_data,
  input  logic                rx_valid,
  input  logic                rx_last,
  buf_wr_if.wr                wr,
  output logic                hdr_push,
  output mpd_pkg::fw_header_t hdr_data
);
  import mpd_pkg::*;

  // Index of the byte now on rx_data, saturates at MAX_FRAME_LEN
  frame_len_t idx;
  logic       claimed;
  slot_id_t   cur_slot;
  logic       first;
  logic       overflow;
  logic       in_window;

  // Tuple registers and their values after this cycle's byte
  ip_proto_t  proto_q;
  ip_proto_t  proto_nxt;
  ipv4_addr_t src_ip_q;
  ipv4_addr_t src_ip_nxt;
  ipv4_addr_t dst_ip_q;
  ipv4_addr_t dst_ip_nxt;
  l4_port_t   src_port_q;
  l4_port_t   src_port_nxt;
  l4_port_t   dst_port_q;
  l4_port_t   dst_port_nxt;

  // ============================================================
  // Frame control
  // ============================================================
  assign first     = (idx == '0);
  // A byte seen at the saturated index means the frame overran its slot
  assign overflow  = (idx == frame_len_t'(MAX_FRAME_LEN));
  assign in_window = !overflow && (idx >= frame_len_t'(MIN_FRAME_LEN - 1));

  // Single-byte frames never claim a slot
  assign wr.alloc  = rx_valid && first && !rx_last && wr.slot_avail;
  assign wr.wr_en  = rx_valid && (claimed || wr.alloc) && !overflow;
  assign wr.addr   = buf_addr_t'(idx);
  assign wr.data   = rx_data;
  assign wr.commit = rx_valid && rx_last && claimed && in_window;
  assign wr.abort  = rx_valid && rx_last && claimed && !in_window;
  assign wr.len    = idx + frame_len_t'(1);
  assign hdr_push  = wr.commit;

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      idx      <= '0;
      claimed  <= 1'b0;
      cur_slot <= '0;
    end else if (rx_valid) begin
      if (rx_last) begin
        idx     <= '0;
        claimed <= 1'b0;
      end else begin
        if (!overflow) begin
          idx <= idx + frame_len_t'(1);
        end
        // No free slot here leaves the frame skipped until rx_last
        if (wr.alloc) begin
          claimed  <= 1'b1;
          cur_slot <= wr.free_slot;
        end
      end
    end
  end

  // ============================================================
  // Tuple extraction
  // ============================================================
  always_comb begin
    proto_nxt    = proto_q;
    src_ip_nxt   = src_ip_q;
    dst_ip_nxt   = dst_ip_q;
    src_port_nxt = src_port_q;
    dst_port_nxt = dst_port_q;
    if (rx_valid) begin
      if (idx == frame_len_t'(OFS_PROTO)) begin
        proto_nxt = rx_data;
      end
      // Multi-byte fields arrive in network order, MSB first
      if (idx >= frame_len_t'(OFS_SRC_IP) && idx < frame_len_t'(OFS_SRC_IP + 4)) begin
        src_ip_nxt = {src_ip_q[23:0], rx_data};
      end
      if (idx >= frame_len_t'(OFS_DST_IP) && idx < frame_len_t'(OFS_DST_IP + 4)) begin
        dst_ip_nxt = {dst_ip_q[23:0], rx_data};
      end
      if (idx >= frame_len_t'(OFS_SRC_PORT) && idx < frame_len_t'(OFS_SRC_PORT + 2)) begin
        src_port_nxt = {src_port_q[7:0], rx_data};
      end
      if (idx >= frame_len_t'(OFS_DST_PORT) && idx < frame_len_t'(OFS_DST_PORT + 2)) begin
        dst_port_nxt = {dst_port_q[7:0], rx_data};
      end
    end
  end

  always_ff @(posedge CLK) begin
    proto_q    <= proto_nxt;
    src_ip_q   <= src_ip_nxt;
    dst_ip_q   <= dst_ip_nxt;
    src_port_q <= src_port_nxt;
    dst_port_q <= dst_port_nxt;
  end

  // Built from the next values so a 38-byte frame's final port byte is included
  always_comb begin
    hdr_data = '0;
    hdr_data[HDR_DST_IP_LSB +: $bits(ipv4_addr_t)]   = dst_ip_nxt;
    hdr_data[HDR_DST_PORT_LSB +: $bits(l4_port_t)]   = dst_port_nxt;
    hdr_data[HDR_PROTO_LSB +: $bits(ip_proto_t)]     = proto_nxt;
    hdr_data[HDR_SRC_IP_LSB +: $bits(ipv4_addr_t)]   = src_ip_nxt;
    hdr_data[HDR_SRC_PORT_LSB +: $bits(l4_port_t)]   = src_port_nxt;
    hdr_data[HDR_SLOT_LSB +: $bits(slot_id_t)]       = cur_slot;
  end

  // Bytes after the first go to a slot the buffer still holds busy
  a_wr_claimed: assert property (@(posedge CLK) disable iff (!RST_N)
    wr.wr_en && !wr.alloc |-> !(wr.slot_avail && wr.free_slot == cur_slot));

endmodule

//--- hw/frame_transmitter.sv
`timescale 1ns/1ps

module frame_transmitter (
  input  logic                CLK,
  input  logic                RST_N,
  input  mpd_pkg::fw_result_t res_data,
  input  logic                res_valid,
  output logic                res_pop,
  buf_rd_if.rd                rd,
  output mpd_pkg::byte_t      tx_data,
  output logic                tx_valid,
  output logic                tx_last,
  input  logic                tx_ready
);
  import mpd_pkg::*;

  tx_state_t state;
  tx_state_t state_nxt;
  // Slot and byte address of the frame on the wire
  slot_id_t  slot_q;
  buf_addr_t idx;
  logic      is_pass;
  logic      tx_done;

  // ============================================================
  // Verdict dispatch and slot release
  // ============================================================
  assign is_pass = res_data[RES_PASS_BIT];
  assign res_pop = (state == TX_IDLE) && res_valid;
  assign tx_done = (state == TX_SEND) && tx_ready && tx_last;

  // Idle reads address the verdict's slot so a drop can release it at once
  assign rd.slot        = (state == TX_IDLE) ? slot_id_t'(res_data[RES_SLOT_BIT]) : slot_q;
  assign rd.addr        = idx;
  assign rd.release_stb = (res_pop && !is_pass) || tx_done;

  // A byte is offered for the whole SEND state
  assign tx_valid = (state == TX_SEND);

  // ============================================================
  // Transmit FSM
  // ============================================================
  always_comb begin
    state_nxt = state;
    case (state)
      TX_IDLE: begin
        if (res_pop && is_pass) begin
          state_nxt = TX_FETCH;
        end
      end
      TX_FETCH: begin
        state_nxt = TX_SEND;
      end
      TX_SEND: begin
        if (tx_ready) begin
          state_nxt = tx_last ? TX_IDLE : TX_FETCH;
        end
      end
      default: begin
        state_nxt = TX_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      state   <= TX_IDLE;
      slot_q  <= '0;
      idx     <= '0;
      tx_last <= 1'b0;
    end else begin
      state <= state_nxt;
      if (res_pop && is_pass) begin
        slot_q <= res_data[RES_SLOT_BIT];
        idx    <= '0;
      end
      // Last byte is the one at stored length minus one
      if (state == TX_FETCH) begin
        tx_last <= ((frame_len_t'(idx) + frame_len_t'(1)) == rd.len);
      end
      if (state == TX_SEND && tx_ready && !tx_last) begin
        idx <= idx + 1'b1;
      end
    end
  end

  // Output byte latched once per FETCH, held through SEND
  always_ff @(posedge CLK) begin
    if (state == TX_FETCH) begin
      tx_data <= rd.data;
    end
  end

  a_tx_hold: assert property (@(posedge CLK) disable iff (!RST_N)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last));

endmodule

//--- hw/mpd_pkg.sv
package mpd_pkg;

  // ============================================================
  // Stream and tuple field types
  // ============================================================
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] l4_port_t;
  typedef logic [7:0]  ip_proto_t;
  typedef logic [0:0]  slot_id_t;
  typedef logic [5:0]  buf_addr_t;
  // Holds 0 to 64, one bit wider than a byte address
  typedef logic [6:0]  frame_len_t;

  // ============================================================
  // Buffer geometry and frame limits
  // ============================================================
  localparam int NUM_SLOTS     = 2;
  localparam int MAX_FRAME_LEN = 64;
  localparam int MIN_FRAME_LEN = 38;

  // Byte offsets in an untagged Ethernet frame carrying IPv4 without options
  localparam int OFS_PROTO    = 23;
  localparam int OFS_SRC_IP   = 26;
  localparam int OFS_DST_IP   = 30;
  localparam int OFS_SRC_PORT = 34;
  localparam int OFS_DST_PORT = 36;

  // ============================================================
  // Firewall words
  // ============================================================
  localparam int HDR_W = 105;
  localparam int RES_W = 2;

  // Header layout, from the bottom up
  localparam int HDR_SLOT_LSB     = 0;
  localparam int HDR_SRC_PORT_LSB = 1;
  localparam int HDR_SRC_IP_LSB   = 17;
  localparam int HDR_PROTO_LSB    = 49;
  localparam int HDR_DST_PORT_LSB = 57;
  localparam int HDR_DST_IP_LSB   = 73;

  // Verdict layout
  localparam int RES_PASS_BIT = 0;
  localparam int RES_SLOT_BIT = 1;

  typedef logic [HDR_W-1:0] fw_header_t;
  typedef logic [RES_W-1:0] fw_result_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_FETCH,
    TX_SEND
  } tx_state_t;

endpackage

//--- hw/mpd_top.sv
`timescale 1ns/1ps

module mpd_top (
  input  logic                CLK,
  input  logic                RST_N,
  input  mpd_pkg::byte_t      rx_data,
  input  logic                rx_valid,
  input  logic                rx_last,
  output mpd_pkg::byte_t      tx_data,
  output logic                tx_valid,
  output logic                tx_last,
  input  logic                tx_ready,
  output mpd_pkg::fw_header_t header_data,
  output logic                header_valid,
  input  logic                header_ready,
  input  mpd_pkg::fw_result_t result_data,
  input  logic                result_valid,
  output logic                result_ready
);
  import mpd_pkg::*;

  // Receiver to header queue
  logic       hdr_push;
  fw_header_t hdr_word;
  logic       hdr_pop;

  // Result queue to transmitter
  logic       res_push;
  fw_result_t res_word;
  logic       res_valid;
  logic       res_pop;

  buf_wr_if wr_bus ();
  buf_rd_if rd_bus ();

  // ============================================================
  // Datapath blocks
  // ============================================================
  frame_receiver u_rx (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_last  (rx_last),
    .wr       (wr_bus.wr),
    .hdr_push (hdr_push),
    .hdr_data (hdr_word)
  );

  packet_buffer u_buf (
    .CLK   (CLK),
    .RST_N (RST_N),
    .wr    (wr_bus.mem),
    .rd    (rd_bus.mem)
  );

  frame_transmitter u_tx (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .res_data  (res_word),
    .res_valid (res_valid),
    .res_pop   (res_pop),
    .rd        (rd_bus.rd),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_last   (tx_last),
    .tx_ready  (tx_ready)
  );

  // ============================================================
  // Firewall queues, one entry per slot each
  // ============================================================
  assign hdr_pop  = header_valid && header_ready;
  assign res_push = result_valid && result_ready;

  sync_fifo #(.WIDTH(HDR_W), .DEPTH(NUM_SLOTS)) u_hdr_q (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .push      (hdr_push),
    .push_data (hdr_word),
    .pop       (hdr_pop),
    .pop_data  (header_data),
    .not_empty (header_valid),
    .not_full  ()
  );

  sync_fifo #(.WIDTH(RES_W), .DEPTH(NUM_SLOTS)) u_res_q (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .push      (res_push),
    .push_data (result_data),
    .pop       (res_pop),
    .pop_data  (res_word),
    .not_empty (res_valid),
    .not_full  (result_ready)
  );

endmodule

//--- hw/packet_buffer.sv
`timescale 1ns/1ps

module packet_buffer (
  input logic   CLK,
  input logic   RST_N,
  buf_wr_if.mem wr,
  buf_rd_if.mem rd
);
  import mpd_pkg::*;

  // ============================================================
  // Slot storage and bookkeeping
  // ============================================================
  byte_t                mem   [NUM_SLOTS][MAX_FRAME_LEN];
  frame_len_t           len_q [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] busy;
  // Slot owned by the frame being received
  slot_id_t             wr_slot;
  slot_id_t             cur_wr;

  // Lowest free slot wins, scanned from the top down
  always_comb begin
    wr.free_slot = '0;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        wr.free_slot = slot_id_t'(i);
      end
    end
  end

  assign wr.slot_avail = ~&busy;

  // The first byte lands in the same cycle as its alloc
  assign cur_wr = wr.alloc ? wr.free_slot : wr_slot;

  always_ff @(posedge CLK) begin
    if (wr.wr_en) begin
      mem[cur_wr][wr.addr] <= wr.data;
    end
    if (wr.commit) begin
      len_q[wr_slot] <= wr.len;
    end
  end

  // Busy from alloc until abort or release
  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      busy    <= '0;
      wr_slot <= '0;
    end else begin
      if (wr.alloc) begin
        busy[wr.free_slot] <= 1'b1;
        wr_slot            <= wr.free_slot;
      end
      if (wr.abort) begin
        busy[wr_slot] <= 1'b0;
      end
      if (rd.release_stb) begin
        busy[rd.slot] <= 1'b0;
      end
    end
  end

  // Read port for the transmitter
  assign rd.data = mem[rd.slot][rd.addr];
  assign rd.len  = len_q[rd.slot];

  a_alloc_free: assert property (@(posedge CLK) disable iff (!RST_N)
    wr.alloc |-> wr.slot_avail);
  a_release_busy: assert property (@(posedge CLK) disable iff (!RST_N)
    rd.release_stb |-> busy[rd.slot]);

endmodule

//--- hw/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             CLK,
  input  logic             RST_N,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             not_empty,
  output logic             not_full
);

  // Storage, written at wr_ptr and read at rd_ptr
  logic [WIDTH-1:0]             mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;

  assign pop_data  = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign not_full  = (int'(count) != DEPTH);

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_no_overflow: assert property (@(posedge CLK) disable iff (!RST_N) push |-> not_full);
  a_no_underflow: assert property (@(posedge CLK) disable iff (!RST_N) pop |-> not_empty);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert -Wno-fatal --top-module tb_mpd \
  -f verilog.f 2>&1 && ./obj_dir/Vtb_mpd 2>&1) || { echo "$out"; echo "Build or run failed"; exit 1; }
echo "$out"
echo "$out" | grep -qx '\*\* PASS \*\*' && exit 0 || exit 1

//--- tb/tb_mpd.sv
`timescale 1ns/1ps

module tb_mpd;
  import mpd_pkg::*;

  localparam int CYCLE_NS = 40;
  localparam int N_ROWS   = 13;
  // Verdict codes of the stimulus table
  localparam int V_PASS = 0;
  localparam int V_DROP = 1;
  localparam int V_HOLD = 2;

  typedef struct {
    int len;
    int verdict;
    int seed;
    bit stall;
    int exp_slot;
  } row_t;

  logic       CLK;
  logic       RST_N;
  byte_t      rx_data;
  logic       rx_valid;
  logic       rx_last;
  byte_t      tx_data;
  logic       tx_valid;
  logic       tx_last;
  logic       tx_ready;
  fw_header_t header_data;
  logic       header_valid;
  logic       header_ready;
  fw_result_t result_data;
  logic       result_valid;
  logic       result_ready;

  row_t        rows [N_ROWS];
  byte_t       frame [80];
  // Reference model of the two slots
  bit          busy [2];
  byte_t       slot_bytes [2][64];
  int          slot_len [2];
  int          held [$];
  // Expected transmit stream, tx_last in bit 8
  logic [8:0]  exp_q [$];
  logic [8:0]  tx_exp;
  logic [31:0] stall_state;
  logic [31:0] drv_state;
  bit          stall_en;
  int          errors;
  int          tx_count;
  int          frames_done;

  mpd_top i_dut (
    .CLK          (CLK),
    .RST_N        (RST_N),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_last      (rx_last),
    .tx_data      (tx_data),
    .tx_valid     (tx_valid),
    .tx_last      (tx_last),
    .tx_ready     (tx_ready),
    .header_data  (header_data),
    .header_valid (header_valid),
    .header_ready (header_ready),
    .result_data  (result_data),
    .result_valid (result_valid),
    .result_ready (result_ready)
  );

  initial CLK = 1'b0;
  always #(CYCLE_NS / 2) CLK = ~CLK;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Tuple fields in network order, slot id in the lowest bit
  function automatic fw_header_t expected_header(input int slot);
    byte_t b [64];
    b = slot_bytes[slot];
    return {b[30], b[31], b[32], b[33], b[36], b[37], b[23],
            b[26], b[27], b[28], b[29], b[34], b[35], slot[0]};
  endfunction

  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic build_frame(input int seed, input int len);
    logic [31:0] s;
    s = 32'h1c37 + seed;
    for (int i = 0; i < len; i++) begin
      s = lcg_next(s);
      frame[i] = s[23:16];
    end
  endtask

  // Random one-cycle gaps inside the frame when stalls are on
  task automatic send_frame(input int len);
    for (int i = 0; i < len; i++) begin
      rx_data  = frame[i];
      rx_valid = 1'b1;
      rx_last  = (i == len - 1);
      next_cycle();
      drv_state = lcg_next(drv_state);
      if (stall_en && drv_state[31:30] == 2'b00 && i != len - 1) begin
        rx_valid = 1'b0;
        next_cycle();
      end
    end
    rx_valid = 1'b0;
    rx_last  = 1'b0;
  endtask

  task automatic take_header(input int slot);
    fw_header_t exp;
    int         delay;
    // Header valid is due one cycle after the last byte
    @(negedge CLK);
    if (header_valid !== (slot >= 0)) begin
      errors++;
      $display("ERR %0t: header_valid is %b after last byte", $time, header_valid);
    end
    if (slot >= 0) begin
      exp   = expected_header(slot);
      delay = 0;
      if (stall_en) begin
        drv_state = lcg_next(drv_state);
        delay = 1 + int'(drv_state[25:24]);
      end
      next_cycle();
      repeat (delay) next_cycle();
      header_ready = 1'b1;
      @(negedge CLK);
      if (!header_valid || header_data !== exp) begin
        errors++;
        $display("ERR %0t: header %h, expected %h", $time, header_data, exp);
      end
      next_cycle();
      header_ready = 1'b0;
    end else begin
      repeat (3) begin
        @(negedge CLK);
        if (header_valid) begin
          errors++;
          $display("ERR %0t: header for a rejected frame", $time);
        end
      end
      next_cycle();
    end
  endtask

  // Drop frees the slot within two cycles, pass after the last byte
  task automatic give_verdict(input int slot, input bit pass);
    result_data  = {slot[0], pass};
    result_valid = 1'b1;
    if (pass) begin
      for (int i = 0; i < slot_len[slot]; i++) begin
        exp_q.push_back({i == slot_len[slot] - 1, slot_bytes[slot][i]});
      end
    end
    @(negedge CLK);
    if (!result_ready) begin
      errors++;
      $display("ERR %0t: result_ready low with a free queue entry", $time);
    end
    next_cycle();
    result_valid = 1'b0;
    while (exp_q.size() != 0) next_cycle();
    repeat (3) next_cycle();
    busy[slot] = 1'b0;
  endtask

  task automatic flush_held();
    while (held.size() != 0) begin
      give_verdict(held.pop_front(), 1'b1);
    end
  endtask

  // ============================================================
  // Transmit side: random ready and byte checker
  // ============================================================
  always @(posedge CLK) begin
    #2;
    stall_state = lcg_next(stall_state);
    tx_ready = !stall_en || (stall_state[31:30] != 2'b00);
  end

  // Sampled mid-cycle, the handshake follows at the next rising edge
  always @(negedge CLK) begin
    if (RST_N && tx_valid && tx_ready) begin
      tx_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERR %0t: unexpected tx byte %h", $time, tx_data);
      end else begin
        tx_exp = exp_q.pop_front();
        if ({tx_last, tx_data} !== tx_exp) begin
          errors++;
          $display("ERR %0t: tx last/byte %b/%h, expected %b/%h", $time,
                   tx_last, tx_data, tx_exp[8], tx_exp[7:0]);
        end
      end
    end
  end

  // ============================================================
  // Stimulus table and main sequence
  // ============================================================
  initial begin
    int slot;
    rows[0]  = '{40, V_PASS, 1, 1'b0, 0};
    rows[1]  = '{64, V_DROP, 2, 1'b0, 0};
    rows[2]  = '{38, V_PASS, 3, 1'b1, 0};
    rows[3]  = '{20, V_PASS, 4, 1'b0, -1};
    rows[4]  = '{70, V_DROP, 5, 1'b0, -1};
    rows[5]  = '{50, V_HOLD, 6, 1'b0, 0};
    rows[6]  = '{45, V_HOLD, 7, 1'b1, 1};
    // Both slots held, so this one is refused
    rows[7]  = '{42, V_PASS, 8, 1'b1, -1};
    rows[8]  = '{39, V_HOLD, 9, 1'b0, 0};
    rows[9]  = '{60, V_DROP, 10, 1'b1, 1};
    rows[10] = '{55, V_PASS, 11, 1'b1, 1};
    rows[11] = '{37, V_DROP, 12, 1'b0, -1};
    rows[12] = '{64, V_PASS, 13, 1'b1, 0};
    RST_N = 1'b0;
    rx_data = '0;
    rx_valid = 1'b0;
    rx_last = 1'b0;
    tx_ready = 1'b1;
    header_ready = 1'b0;
    result_data = '0;
    result_valid = 1'b0;
    stall_state = 32'h1c37;
    drv_state = 32'h1c37;
    stall_en = 1'b0;
    errors = 0;
    tx_count = 0;
    frames_done = 0;
    busy = '{1'b0, 1'b0};
    repeat (4) @(posedge CLK);
    #2 RST_N = 1'b1;
    @(negedge CLK);
    if (tx_valid || header_valid || !result_ready) begin
      errors++;
      $display("ERR %0t: outputs not in their reset state", $time);
    end
    next_cycle();
    for (int r = 0; r < N_ROWS; r++) begin
      stall_en = rows[r].stall;
      build_frame(rows[r].seed, rows[r].len);
      // Lowest free slot, only for a frame inside the length window
      slot = -1;
      if (rows[r].len >= 38 && rows[r].len <= 64) begin
        for (int s = 1; s >= 0; s--) begin
          if (!busy[s]) slot = s;
        end
      end
      if (slot != rows[r].exp_slot) begin
        errors++;
        $display("Row %0d: model slot %0d does not match the table", r, slot);
      end
      if (slot >= 0) begin
        busy[slot] = 1'b1;
        slot_len[slot] = rows[r].len;
        for (int i = 0; i < rows[r].len; i++) slot_bytes[slot][i] = frame[i];
      end
      send_frame(rows[r].len);
      take_header(slot);
      if (slot >= 0) begin
        if (rows[r].verdict == V_HOLD) held.push_back(slot);
        else give_verdict(slot, rows[r].verdict == V_PASS);
      end
      if (slot < 0 || rows[r].verdict == V_PASS) flush_held();
      frames_done++;
    end
    flush_held();
    repeat (5) next_cycle();
    if (exp_q.size() != 0) begin
      errors++;
      $display("Transmit ended with %0d bytes still expected", exp_q.size());
    end
    $display("tb_mpd: %0d frames, %0d tx bytes, %0d errors", frames_done, tx_count, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog, 200 cycles for each table row
  initial begin
    #(N_ROWS * 200 * CYCLE_NS);
    $display("Timeout: the run did not finish in %0d cycles", N_ROWS * 200);
    $display("tb_mpd: %0d frames, %0d tx bytes, %0d errors", frames_done, tx_count, errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- verilog.f
hw/mpd_pkg.sv
hw/buf_if.sv
hw/sync_fifo.sv
hw/packet_buffer.sv
hw/frame_receiver.sv
hw/frame_transmitter.sv
hw/mpd_top.sv
tb/tb_mpd.sv
